/* Makefile */
# Verilator build and run of the block cache testbench

SIM      ?= verilator
TOP      ?= tb_block_cache
FILELIST ?= block_cache.f
BUILD    ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert -Wno-fatal
PASS_MSG := ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: SIM TOP FILELIST BUILD LOG VFLAGS"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* block_cache.f */
common/cache_pkg.sv
rtl/line_ram.sv
rtl/cache_stats.sv
cache_ctrl/tag_store.sv
cache_ctrl/cache_ctrl_fsm.sv
rtl/block_cache_top.sv
testbench/mem_model.sv
testbench/tb_block_cache.sv

/* cache_ctrl/cache_ctrl_fsm.sv */
module cache_ctrl_fsm
	import cache_pkg::*;
#(
	parameter int LINES = 4,
	localparam int LINE_W = $clog2(LINES)
) (
	input  logic                      clock_i,
	input  logic                      resetn_i,

	// core side
	input  logic                      core_req_i,
	input  addr_t                     core_addr_i,
	input  logic                      core_rw_i,       // 1 = store
	input  word_t                     core_data_i,
	output logic                      core_done_o,
	output word_t                     core_data_o,

	// tag store
	input  logic                      tag_hit_i,
	input  logic [LINE_W-1:0]         hit_line_i,
	input  tag_t                      victim_tag_i,
	output logic                      tag_wren_o,
	output logic [LINE_W-1:0]         tag_wr_line_o,
	output logic [LINE_W-1:0]         victim_line_o,

	// line ram
	input  word_t                     ram_rdata_i,
	output logic [LINE_W+BLOCK_W-1:0] ram_addr_o,
	output logic                      ram_wren_o,
	output word_t                     ram_wdata_o,

	// memory buffers and command port
	input  logic                      mem_ready_i,
	input  logic                      buffer_read_ready_i,
	input  word_t                     buffer_data_i,
	input  logic                      buffer_write_ready_i,
	output logic                      buffer_read_ack_o,
	output logic                      buffer_write_ack_o,
	output word_t                     buffer_data_o,
	output logic                      mem_req_o,
	output logic                      mem_req_block_o,
	output logic                      mem_rw_o,        // 1 = write
	output addr_t                     mem_addr_o,

	// statistics events
	output logic                      ev_hit_o,
	output logic                      ev_miss_o,
	output logic                      ev_writeback_o
);

	ctrl_state_t        state;
	logic               req_flag;     // request parked across a miss
	logic [LINES-1:0]   dirty;
	logic [LINE_W-1:0]  victim_ptr;   // round-robin replacement
	logic [BLOCK_W-1:0] n_xfer;       // word counter for block moves
	logic               wb_pend;      // block write waiting for the command port
	addr_t              wb_addr;

	logic               active;
	logic               last_word;
	logic               rd_req;
	logic               wb_req;
	tag_t               req_tag;
	logic [BLOCK_W-1:0] req_word;

	assign req_tag   = core_addr_i[ADDR_W-1:BLOCK_W];
	assign req_word  = core_addr_i[BLOCK_W-1:0];
	assign active    = (state == ST_NORMAL) & (core_req_i | req_flag);
	assign last_word = (n_xfer == BLOCK_W'(BLOCK_WORDS - 1));

	// ------------------------------------------------------------------
	// command port, read and writeback requests never overlap
	// ------------------------------------------------------------------
	assign rd_req = (state == ST_WAIT_READY) & mem_ready_i & ~wb_pend;
	assign wb_req = wb_pend & mem_ready_i;

	assign mem_req_o       = rd_req | wb_req;
	assign mem_req_block_o = rd_req | wb_req;   // whole blocks only
	assign mem_rw_o        = wb_req;
	assign mem_addr_o      = wb_req ? wb_addr : {req_tag, {BLOCK_W{1'b0}}};

	// buffer strobes follow the ready levels in the same cycle
	assign buffer_read_ack_o  = (state == ST_READ_BUFFER) & buffer_read_ready_i;
	assign buffer_write_ack_o = (state == ST_WRITE_BUFFER) & buffer_write_ready_i;
	assign buffer_data_o      = ram_rdata_i;    // victim word being copied out

	// line ram port
	always_comb begin
		case (state)
			ST_WRITE_BUFFER,
			ST_READ_BUFFER: ram_addr_o = {victim_ptr, n_xfer};
			default:        ram_addr_o = {hit_line_i, req_word};
		endcase
	end
	assign ram_wren_o  = (active & tag_hit_i & core_rw_i) | buffer_read_ack_o;
	assign ram_wdata_o = (state == ST_READ_BUFFER) ? buffer_data_i : core_data_i;

	// tag written with the last fill word
	assign tag_wren_o    = buffer_read_ack_o & last_word;
	assign tag_wr_line_o = victim_ptr;
	assign victim_line_o = victim_ptr;

	// events, retried request after a fill is not a hit
	assign ev_hit_o       = active & ~req_flag & tag_hit_i;
	assign ev_miss_o      = active & ~tag_hit_i;
	assign ev_writeback_o = (state == ST_WAIT_VICTIM) & dirty[victim_ptr];

	// ------------------------------------------------------------------
	// control state
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state       <= ST_NORMAL;
			req_flag    <= 1'b0;
			dirty       <= '0;
			victim_ptr  <= '1;            // first fill rolls over to line 0
			n_xfer      <= '0;
			wb_pend     <= 1'b0;
			core_done_o <= 1'b1;
		end else begin
			if (wb_req)
				wb_pend <= 1'b0;          // writeback handed to memory

			case (state)
				ST_NORMAL: begin
					if (active) begin
						if (tag_hit_i) begin
							req_flag    <= 1'b0;
							core_done_o <= 1'b1;
							if (core_rw_i)
								dirty[hit_line_i] <= 1'b1;
						end else begin
							req_flag    <= 1'b1;   // retry after fill
							core_done_o <= 1'b0;   // stall core
							state       <= ST_WAIT_READY;
						end
					end
				end

				ST_WAIT_READY: begin
					if (rd_req) begin
						victim_ptr <= victim_ptr + 1'b1;
						state      <= ST_WAIT_VICTIM;
					end
				end

				ST_WAIT_VICTIM: begin
					// victim tag valid here, captured below
					state <= dirty[victim_ptr] ? ST_WRITE_BUFFER : ST_READ_BUFFER;
				end

				ST_WRITE_BUFFER: begin
					if (buffer_write_ack_o) begin
						n_xfer <= n_xfer + 1'b1;       // wraps back to 0
						if (last_word) begin
							dirty[victim_ptr] <= 1'b0;
							wb_pend           <= 1'b1;  // block now in write buffer
							state             <= ST_READ_BUFFER;
						end
					end
				end

				ST_READ_BUFFER: begin
					if (buffer_read_ack_o) begin
						n_xfer <= n_xfer + 1'b1;
						if (last_word)
							state <= ST_NORMAL;       // parked request hits now
					end
				end

				default: state <= ST_NORMAL;
			endcase
		end
	end

	// load data and writeback address
	always_ff @(posedge clock_i) begin
		if (active & tag_hit_i & ~core_rw_i)
			core_data_o <= ram_rdata_i;
		if (state == ST_WAIT_VICTIM)
			wb_addr <= {victim_tag_i, {BLOCK_W{1'b0}}};
	end

	// memory side strobe rules
	a_mem_req_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_o |-> mem_ready_i);
	a_rd_ack_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_read_ack_o |-> buffer_read_ready_i);

endmodule

/* cache_ctrl/tag_store.sv */
module tag_store
	import cache_pkg::*;
#(
	parameter int LINES = 4,
	localparam int LINE_W = $clog2(LINES)
) (
	input  logic              clock_i,
	input  logic              resetn_i,
	input  tag_t              lookup_tag_i,
	input  logic              wren_i,
	input  logic [LINE_W-1:0] wr_line_i,
	input  tag_t              wr_tag_i,
	input  logic [LINE_W-1:0] victim_line_i,
	output logic              hit_o,
	output logic [LINE_W-1:0] hit_line_o,
	output tag_t              victim_tag_o
);

	tag_t             tags [LINES];
	logic [LINES-1:0] valid;
	logic [LINES-1:0] match;

	// ------------------------------------------------------------------
	// parallel compare and encode
	// ------------------------------------------------------------------
	always_comb begin
		hit_line_o = '0;
		for (int i = 0; i < LINES; i++) begin
			match[i] = valid[i] & (tags[i] == lookup_tag_i);
			if (match[i])
				hit_line_o = hit_line_o | LINE_W'(i);   // one-hot, so or-encode
		end
	end

	assign hit_o        = |match;
	assign victim_tag_o = tags[victim_line_i];   // forms writeback address

	// valid bits
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			valid <= '0;
		else if (wren_i)
			valid[wr_line_i] <= 1'b1;
	end

	// tag array
	always_ff @(posedge clock_i) begin
		if (wren_i)
			tags[wr_line_i] <= wr_tag_i;
	end

	// a block lives in at most one line
	a_one_match: assert property (@(posedge clock_i) disable iff (!resetn_i)
		$onehot0(match));

endmodule

/* common/cache_pkg.sv */
package cache_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int WORD_W      = 32;                 // core data word
	localparam int ADDR_W      = 16;                 // word address
	localparam int BLOCK_W     = 2;                  // word within block
	localparam int BLOCK_WORDS = 1 << BLOCK_W;       // 4 words per block
	localparam int TAG_W       = ADDR_W - BLOCK_W;   // block address, no set field
	localparam int STAT_W      = 16;                 // event counter width

	// ------------------------------------------------------------------
	// shared types
	// ------------------------------------------------------------------
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0]  tag_t;

	// controller states
	typedef enum logic [2:0] {
		ST_NORMAL       = 3'd0,   // hit/miss check
		ST_WAIT_READY   = 3'd1,   // wait for memory to take the block read
		ST_WAIT_VICTIM  = 3'd2,   // victim pointer settled, check dirty bit
		ST_WRITE_BUFFER = 3'd3,   // victim words into write buffer
		ST_READ_BUFFER  = 3'd4    // read buffer into victim line
	} ctrl_state_t;

	// statistics counter select
	typedef enum logic [1:0] {
		STAT_HIT       = 2'd0,
		STAT_MISS      = 2'd1,
		STAT_WRITEBACK = 2'd2
	} stat_sel_t;

endpackage

/* rtl/block_cache_top.sv */
module block_cache_top
	import cache_pkg::*;
#(
	parameter int LINES = 4,
	localparam int LINE_W = $clog2(LINES)
) (
	input  logic              clock_i,
	input  logic              resetn_i,

	// core
	input  logic              core_req_i,
	input  addr_t             core_addr_i,
	input  logic              core_rw_i,
	input  word_t             core_data_i,
	output logic              core_done_o,
	output word_t             core_data_o,

	// memory command port and buffers
	input  logic              mem_ready_i,
	output logic              mem_req_o,
	output logic              mem_req_block_o,
	output logic              mem_rw_o,
	output addr_t             mem_addr_o,
	input  logic              buffer_read_ready_i,
	input  word_t             buffer_data_i,
	output logic              buffer_read_ack_o,
	input  logic              buffer_write_ready_i,
	output word_t             buffer_data_o,
	output logic              buffer_write_ack_o,

	// statistics
	input  stat_sel_t         stat_sel_i,
	input  logic              stat_clear_i,
	output logic [STAT_W-1:0] stat_count_o
);

	// ------------------------------------------------------------------
	// internal links
	// ------------------------------------------------------------------
	logic                      tag_hit;
	logic [LINE_W-1:0]         hit_line;
	tag_t                      victim_tag;
	logic                      tag_wren;
	logic [LINE_W-1:0]         tag_wr_line;
	logic [LINE_W-1:0]         victim_line;
	logic [LINE_W+BLOCK_W-1:0] ram_addr;
	logic                      ram_wren;
	word_t                     ram_wdata;
	word_t                     ram_rdata;
	logic                      ev_hit;
	logic                      ev_miss;
	logic                      ev_writeback;

	cache_ctrl_fsm #(.LINES(LINES)) u_ctrl (
		.clock_i, .resetn_i,
		.core_req_i, .core_addr_i, .core_rw_i, .core_data_i, .core_done_o, .core_data_o,
		.tag_hit_i(tag_hit), .hit_line_i(hit_line), .victim_tag_i(victim_tag),
		.tag_wren_o(tag_wren), .tag_wr_line_o(tag_wr_line), .victim_line_o(victim_line),
		.ram_rdata_i(ram_rdata), .ram_addr_o(ram_addr), .ram_wren_o(ram_wren),
		.ram_wdata_o(ram_wdata),
		.mem_ready_i, .buffer_read_ready_i, .buffer_data_i, .buffer_write_ready_i,
		.buffer_read_ack_o, .buffer_write_ack_o, .buffer_data_o,
		.mem_req_o, .mem_req_block_o, .mem_rw_o, .mem_addr_o,
		.ev_hit_o(ev_hit), .ev_miss_o(ev_miss), .ev_writeback_o(ev_writeback)
	);

	// lookup and fill both use the core's block address
	tag_store #(.LINES(LINES)) u_tags (
		.clock_i, .resetn_i,
		.lookup_tag_i (core_addr_i[ADDR_W-1:BLOCK_W]),
		.wren_i       (tag_wren),
		.wr_line_i    (tag_wr_line),
		.wr_tag_i     (core_addr_i[ADDR_W-1:BLOCK_W]),
		.victim_line_i(victim_line),
		.hit_o        (tag_hit),
		.hit_line_o   (hit_line),
		.victim_tag_o (victim_tag)
	);

	line_ram #(.LINES(LINES)) u_ram (
		.clock_i,
		.addr_i (ram_addr),
		.wren_i (ram_wren),
		.wdata_i(ram_wdata),
		.rdata_o(ram_rdata)
	);

	cache_stats u_stats (
		.clock_i, .resetn_i,
		.ev_hit_i(ev_hit), .ev_miss_i(ev_miss), .ev_writeback_i(ev_writeback),
		.stat_clear_i, .stat_sel_i, .stat_count_o
	);

endmodule

/* rtl/cache_stats.sv */
module cache_stats
	import cache_pkg::*;
(
	input  logic              clock_i,
	input  logic              resetn_i,
	input  logic              ev_hit_i,
	input  logic              ev_miss_i,
	input  logic              ev_writeback_i,
	input  logic              stat_clear_i,
	input  stat_sel_t         stat_sel_i,
	output logic [STAT_W-1:0] stat_count_o
);

	logic [STAT_W-1:0] count [3];   // hit, miss, writeback
	logic [2:0]        ev;

	assign ev = {ev_writeback_i, ev_miss_i, ev_hit_i};

	// ------------------------------------------------------------------
	// saturating counters
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i || stat_clear_i) begin
			for (int i = 0; i < 3; i++)
				count[i] <= '0;
		end else begin
			for (int i = 0; i < 3; i++)
				if (ev[i] && count[i] != '1)
					count[i] <= count[i] + 1'b1;   // stick at max
		end
	end

	// read-back mux
	always_comb begin
		case (stat_sel_i)
			STAT_HIT:       stat_count_o = count[0];
			STAT_MISS:      stat_count_o = count[1];
			STAT_WRITEBACK: stat_count_o = count[2];
			default:        stat_count_o = '0;   // unused select code
		endcase
	end

endmodule

/* rtl/line_ram.sv */
module line_ram
	import cache_pkg::*;
#(
	parameter int LINES = 4,
	localparam int LINE_W = $clog2(LINES),
	localparam int RAM_AW = LINE_W + BLOCK_W
) (
	input  logic              clock_i,
	input  logic [RAM_AW-1:0] addr_i,    // {line, word in block}
	input  logic              wren_i,
	input  word_t             wdata_i,
	output word_t             rdata_o
);

	// ------------------------------------------------------------------
	// data storage, one word per entry
	// ------------------------------------------------------------------
	word_t mem [LINES*BLOCK_WORDS];

	assign rdata_o = mem[addr_i];    // asynchronous read

	always_ff @(posedge clock_i) begin
		if (wren_i)
			mem[addr_i] <= wdata_i;
	end

endmodule

/* testbench/mem_model.sv */
module mem_model
	import cache_pkg::*;
#(
	parameter word_t FILL_PAT = 32'h0,
	parameter int    SEED     = 0
) (
	input  logic  clock_i,
	input  logic  resetn_i,
	input  logic  mem_req_i,
	input  logic  mem_req_block_i,
	input  logic  mem_rw_i,          // 1 = block write
	input  addr_t mem_addr_i,
	output logic  mem_ready_o,
	output logic  buffer_read_ready_o,
	output word_t buffer_data_o,
	input  logic  buffer_read_ack_i,
	output logic  buffer_write_ready_o,
	input  word_t buffer_data_i,
	input  logic  buffer_write_ack_i,
	output addr_t last_wr_addr_o,    // address of the latest block write
	output int    wr_count_o         // block writes seen so far
);
	timeunit 1ns;
	timeprecision 100ps;

	word_t  mem [1 << ADDR_W];
	word_t  rd_fifo [$];             // read buffer toward the cache
	word_t  wr_buf [$];              // write buffer from the cache
	integer seed;
	int     delay;
	logic   rd_busy;                 // block read in flight
	addr_t  rd_addr;

	initial begin
		seed                 = SEED;
		delay                = 0;
		rd_busy              = 1'b0;
		rd_addr              = '0;
		mem_ready_o          = 1'b1;
		buffer_read_ready_o  = 1'b0;
		buffer_data_o        = '0;
		buffer_write_ready_o = 1'b1;
		last_wr_addr_o       = '0;
		wr_count_o           = 0;
		for (int i = 0; i < (1 << ADDR_W); i++)
			mem[i] = {~addr_t'(i), addr_t'(i)} ^ FILL_PAT;   // word tied to its address
	end

	// ------------------------------------------------------------------
	// strobes taken at the rising edge, as the cache sees them
	// ------------------------------------------------------------------
	always @(posedge clock_i) begin
		if (!resetn_i) begin
			rd_fifo.delete();
			wr_buf.delete();
			rd_busy = 1'b0;
		end else begin
			if (buffer_read_ack_i && rd_fifo.size() > 0)
				void'(rd_fifo.pop_front());
			if (buffer_write_ack_i)
				wr_buf.push_back(buffer_data_i);
			if (mem_req_i && mem_req_block_i && mem_rw_i) begin
				for (int i = 0; i < BLOCK_WORDS; i++)
					mem[mem_addr_i + addr_t'(i)] = wr_buf.pop_front();
				last_wr_addr_o <= mem_addr_i;
				wr_count_o     <= wr_count_o + 1;
			end else if (mem_req_i && mem_req_block_i) begin
				rd_busy = 1'b1;
				rd_addr = mem_addr_i;
				delay   = 2 + int'($unsigned($random(seed)) % 8);   // 2 to 9 cycles
			end else if (rd_busy) begin
				if (delay == 0) begin
					for (int i = 0; i < BLOCK_WORDS; i++)
						rd_fifo.push_back(mem[rd_addr + addr_t'(i)]);
					rd_busy = 1'b0;
				end else begin
					delay--;
				end
			end
		end
	end

	// outputs move on the falling edge only
	always @(negedge clock_i) begin
		mem_ready_o          = !rd_busy;
		buffer_read_ready_o  = (rd_fifo.size() != 0);
		buffer_data_o        = (rd_fifo.size() != 0) ? rd_fifo[0] : '0;
		buffer_write_ready_o = (wr_buf.size() < BLOCK_WORDS);   // room for one block
	end

endmodule

/* testbench/tb_block_cache.sv */
module tb_block_cache
	import cache_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int    LINES    = 4;
	localparam int    TIMEOUT  = 200;            // cycles per wait
	localparam int    SEED     = 32'hcc8da6e8;
	localparam word_t FILL_PAT = 32'h5a3c_0ff0;

	logic clock_i, resetn_i, core_req_i, core_rw_i, core_done_o;
	addr_t core_addr_i, mem_addr_o, last_wr_addr;
	word_t core_data_i, core_data_o, buffer_data_i, buffer_data_o;
	logic mem_ready_i, mem_req_o, mem_req_block_o, mem_rw_o;
	logic buffer_read_ready_i, buffer_read_ack_o, buffer_write_ready_i, buffer_write_ack_o;
	stat_sel_t stat_sel_i;
	logic stat_clear_i;
	logic [STAT_W-1:0] stat_count_o, exp_count;
	int wr_count;

	// scoreboard and cache model
	word_t shadow [addr_t];
	tag_t line_tag [LINES];
	logic [LINES-1:0] line_valid, line_dirty;
	int ptr, n_req, n_hit, n_wb, n_blk_wr;
	logic chk_data, chk_count, chk_wb;
	word_t exp_data, rnd;
	addr_t exp_wb_addr;
	integer seed;

	block_cache_top #(.LINES(LINES)) UUT (.*);

	mem_model #(.FILL_PAT(FILL_PAT), .SEED(SEED)) u_mem (
		.clock_i, .resetn_i,
		.mem_req_i(mem_req_o), .mem_req_block_i(mem_req_block_o), .mem_rw_i(mem_rw_o),
		.mem_addr_i(mem_addr_o), .mem_ready_o(mem_ready_i),
		.buffer_read_ready_o(buffer_read_ready_i), .buffer_data_o(buffer_data_i),
		.buffer_read_ack_i(buffer_read_ack_o), .buffer_write_ready_o(buffer_write_ready_i),
		.buffer_data_i(buffer_data_o), .buffer_write_ack_i(buffer_write_ack_o),
		.last_wr_addr_o(last_wr_addr), .wr_count_o(wr_count)
	);

	always #20 clock_i = ~clock_i;

	task automatic stop_run();
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first error");
	endtask

	// ------------------------------------------------------------------
	// checks, armed by the flags set on the falling edge
	// ------------------------------------------------------------------
	a_reset_idle: assert property (@(posedge clock_i) $rose(resetn_i) |-> core_done_o && !mem_req_o)
		else begin
			$display("ERROR core_done_o=%h mem_req_o=%h after reset",
				$sampled(core_done_o), $sampled(mem_req_o));
			stop_run();
		end
	a_req_done: assert property (@(posedge clock_i) core_req_i |-> core_done_o)
		else begin
			$display("core request issued while the cache was still busy");
			stop_run();
		end
	a_load_data: assert property (@(posedge clock_i) chk_data |-> core_data_o == exp_data)
		else begin
			$display("ERROR core_data_o: got %h expected %h (addr %h)",
				$sampled(core_data_o), exp_data, core_addr_i);
			stop_run();
		end
	a_count: assert property (@(posedge clock_i) chk_count |-> stat_count_o == exp_count)
		else begin
			$display("ERROR stat_count_o (sel %h): got %h expected %h",
				stat_sel_i, $sampled(stat_count_o), exp_count);
			stop_run();
		end
	a_wb_addr: assert property (@(posedge clock_i) chk_wb |-> last_wr_addr == exp_wb_addr)
		else begin
			$display("ERROR mem_addr_o of block write: got %h expected %h",
				$sampled(last_wr_addr), exp_wb_addr);
			stop_run();
		end
	a_wb_count: assert property (@(posedge clock_i) chk_wb |-> wr_count == n_blk_wr)
		else begin
			$display("ERROR wr_count: got %h expected %h", $sampled(wr_count), n_blk_wr);
			stop_run();
		end

	function automatic word_t expected_word(addr_t a);
		if (shadow.exists(a))
			return shadow[a];
		return {~a, a} ^ FILL_PAT;      // untouched memory content
	endfunction

	// one core access; model predicts hit, miss and eviction
	task automatic access(input addr_t a, input logic rw, input word_t d);
		tag_t blk;
		int   hit_at;
		int   wait_n;
		logic evict;
		blk    = a[ADDR_W-1:BLOCK_W];
		hit_at = -1;
		evict  = 1'b0;
		for (int i = 0; i < LINES; i++)
			if (line_valid[i] && line_tag[i] == blk)
				hit_at = i;
		n_req++;
		if (hit_at >= 0) begin
			n_hit++;
			if (rw)
				line_dirty[hit_at] = 1'b1;
		end else begin
			ptr = (ptr + 1) % LINES;    // round-robin victim
			if (line_valid[ptr] && line_dirty[ptr]) begin
				evict       = 1'b1;
				n_wb++;
				n_blk_wr++;
				exp_wb_addr = {line_tag[ptr], {BLOCK_W{1'b0}}};
			end
			line_tag[ptr]   = blk;
			line_valid[ptr] = 1'b1;
			line_dirty[ptr] = rw;       // retried store dirties the fresh line
		end
		if (rw)
			shadow[a] = d;
		core_req_i  = 1'b1;
		core_addr_i = a;
		core_rw_i   = rw;
		core_data_i = d;
		@(negedge clock_i);
		core_req_i = 1'b0;
		wait_n     = 0;
		while (!core_done_o) begin
			if (wait_n == TIMEOUT) begin
				$display("timeout: core_done_o stayed low for %0d cycles", TIMEOUT);
				stop_run();
			end
			wait_n++;
			@(negedge clock_i);
		end
		exp_data = expected_word(a);
		chk_data = !rw;
		chk_wb   = evict;
		@(negedge clock_i);
		chk_data = 1'b0;
		chk_wb   = 1'b0;
	endtask

	task automatic expect_count(input stat_sel_t sel, input logic [STAT_W-1:0] n);
		stat_sel_i = sel;
		exp_count  = n;
		chk_count  = 1'b1;
		@(negedge clock_i);
		chk_count  = 1'b0;
	endtask

	// every request is either a hit or a miss
	task automatic check_counters();
		expect_count(STAT_HIT, n_hit);
		expect_count(STAT_MISS, n_req - n_hit);
		expect_count(STAT_WRITEBACK, n_wb);
	endtask

	initial begin
		seed         = SEED;
		clock_i      = 1'b0;
		resetn_i     = 1'b0;
		core_req_i   = 1'b0;
		core_addr_i  = '0;
		core_rw_i    = 1'b0;
		core_data_i  = '0;
		stat_sel_i   = STAT_HIT;
		stat_clear_i = 1'b0;
		{chk_data, chk_count, chk_wb} = '0;
		{exp_data, exp_count, exp_wb_addr} = '0;
		{n_req, n_hit, n_wb, n_blk_wr} = '0;
		ptr        = LINES - 1;
		line_valid = '0;
		line_dirty = '0;
		repeat (16) @(negedge clock_i);
		resetn_i = 1'b1;
		@(negedge clock_i);
		check_counters();

		// cold load, then store and load in that block
		access(16'h0124, 1'b0, '0);
		check_counters();
		access(16'h0125, 1'b1, 32'hdead_beef);
		access(16'h0125, 1'b0, '0);
		check_counters();

		// ------------------------------------------------------------------
		// five fresh blocks push dirty lines out
		// ------------------------------------------------------------------
		for (int i = 0; i < 5; i++)
			access(16'h0200 + addr_t'(i * 28), 1'b1, $random(seed));
		access(16'h0125, 1'b0, '0);   // written back word comes home
		check_counters();

		// random mix over eight blocks
		for (int i = 0; i < 200; i++) begin
			rnd = $random(seed);
			access(16'h0800 + addr_t'(rnd[4:0]), rnd[8], $random(seed));
		end
		check_counters();

		stat_clear_i = 1'b1;
		@(negedge clock_i);
		stat_clear_i = 1'b0;
		{n_req, n_hit, n_wb} = '0;
		check_counters();

		$display("** PASS **");
		$finish;
	end

endmodule
